/* logic/aes_pkg.sv */
package aes_pkg;

   // ##################################################
   // widths
   // ##################################################
   localparam int BLOCK_BITS = 128;  // aes block and key
   localparam int MSG_BITS   = 256;  // two blocks per message

   // one aes state, byte 0 sits in the top byte (fips-197 order)
   typedef union packed {
      logic [0:15][7:0]  bytes;  // subbytes / shiftrows view
      logic [0:3][31:0]  cols;   // mixcolumns / addroundkey view
   } aes_block_u;

   // message or mac, hi half first
   typedef struct packed {
      aes_block_u hi;
      aes_block_u lo;
   } aes_msg_t;

   // ##################################################
   // gf(2^8) helpers
   // ##################################################
   function automatic logic [7:0] aes_xtime(input logic [7:0] a);
      return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
   endfunction

   // full multiply, used by the s-box inverse only
   function automatic logic [7:0] aes_gf_mul(input logic [7:0] a, input logic [7:0] b);
      logic [7:0] acc;
      logic [7:0] x;
      acc = 8'h00;
      x   = a;
      for (int i = 0; i < 8; i++) begin
         if (b[i]) begin
            acc = acc ^ x;
         end
         x = aes_xtime(x);
      end
      return acc;
   endfunction

   // forward s-box: inverse via x^254, then the affine map
   function automatic logic [7:0] aes_sbox(input logic [7:0] a);
      logic [7:0] pw;
      logic [7:0] inv;
      logic [7:0] res;
      pw  = a;
      inv = 8'h01;
      for (int i = 1; i < 8; i++) begin
         pw  = aes_gf_mul(pw, pw);   // x^2, x^4 .. x^128
         inv = aes_gf_mul(inv, pw);
      end
      // zero maps to zero since every factor is zero
      res = inv
          ^ {inv[6:0], inv[7]}
          ^ {inv[5:0], inv[7:6]}
          ^ {inv[4:0], inv[7:5]}
          ^ {inv[3:0], inv[7:4]}
          ^ 8'h63;
      return res;
   endfunction

   // round constant for rounds 1..10
   function automatic logic [7:0] aes_rcon(input logic [3:0] round);
      logic [7:0] rc;
      case (round)
         4'd1:    rc = 8'h01;
         4'd2:    rc = 8'h02;
         4'd3:    rc = 8'h04;
         4'd4:    rc = 8'h08;
         4'd5:    rc = 8'h10;
         4'd6:    rc = 8'h20;
         4'd7:    rc = 8'h40;
         4'd8:    rc = 8'h80;
         4'd9:    rc = 8'h1b;
         4'd10:   rc = 8'h36;
         default: rc = 8'h00;  // outside 1..10
      endcase
      return rc;
   endfunction

endpackage : aes_pkg

/* logic/aes_key_expand.sv */
module aes_key_expand import aes_pkg::*; (
   input  aes_block_u round_key_i,
   input  logic [7:0] rcon_i,
   output aes_block_u next_key_o
);

   logic [0:3][7:0] rot_word;  // rotated last column
   logic [0:3][7:0] sub_word;
   logic [31:0]     temp;
   aes_block_u      next_key;

   // rotword on the last column, bytes 12..15
   always_comb begin
      rot_word[0] = round_key_i.bytes[13];
      rot_word[1] = round_key_i.bytes[14];
      rot_word[2] = round_key_i.bytes[15];
      rot_word[3] = round_key_i.bytes[12];
   end

   // subword
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         sub_word[i] = aes_sbox(rot_word[i]);
      end
   end

   assign temp = sub_word ^ {rcon_i, 24'h000000};  // rcon into the top byte

   // xor chain across the four columns
   always_comb begin
      next_key.cols[0] = round_key_i.cols[0] ^ temp;
      for (int c = 1; c < 4; c++) begin
         next_key.cols[c] = round_key_i.cols[c] ^ next_key.cols[c-1];
      end
   end

   assign next_key_o = next_key;

endmodule : aes_key_expand

/* logic/aes_round.sv */
module aes_round import aes_pkg::*; (
   input  aes_block_u state_i,
   input  aes_block_u round_key_i,
   input  logic       last_i,
   output aes_block_u state_o
);

   aes_block_u sub_st;
   aes_block_u shift_st;
   aes_block_u mix_st;
   aes_block_u out_st;

   // subbytes
   always_comb begin
      for (int i = 0; i < 16; i++) begin
         sub_st.bytes[i] = aes_sbox(state_i.bytes[i]);
      end
   end

   // shiftrows: row r of column c comes from column c+r
   always_comb begin
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++) begin
            shift_st.bytes[4*c + r] = sub_st.bytes[4*((c + r) % 4) + r];
         end
      end
   end

   // mixcolumns, one column word at a time
   always_comb begin
      logic [7:0] a0;
      logic [7:0] a1;
      logic [7:0] a2;
      logic [7:0] a3;
      for (int c = 0; c < 4; c++) begin
         a0 = shift_st.cols[c][31:24];
         a1 = shift_st.cols[c][23:16];
         a2 = shift_st.cols[c][15:8];
         a3 = shift_st.cols[c][7:0];
         mix_st.cols[c][31:24] = aes_xtime(a0) ^ aes_xtime(a1) ^ a1 ^ a2 ^ a3;
         mix_st.cols[c][23:16] = a0 ^ aes_xtime(a1) ^ aes_xtime(a2) ^ a2 ^ a3;
         mix_st.cols[c][15:8]  = a0 ^ a1 ^ aes_xtime(a2) ^ aes_xtime(a3) ^ a3;
         mix_st.cols[c][7:0]   = aes_xtime(a0) ^ a0 ^ a1 ^ a2 ^ aes_xtime(a3);
      end
   end

   // addroundkey, final round bypasses mixcolumns
   always_comb begin
      for (int c = 0; c < 4; c++) begin
         out_st.cols[c] = (last_i ? shift_st.cols[c] : mix_st.cols[c]) ^ round_key_i.cols[c];
      end
   end

   assign state_o = out_st;

endmodule : aes_round

/* logic/aes_core.sv */
module aes_core import aes_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       data_in_valid_i,
   input  aes_block_u key_in_i,
   input  aes_block_u data_in_i,
   output logic       data_out_valid_o,
   output aes_block_u data_out_o
);

   aes_block_u state_q;     // cipher state, ciphertext once done
   aes_block_u rkey_q;      // key of the previous round
   aes_block_u rkey_next;
   aes_block_u state_next;
   logic [7:0] rcon;
   logic [3:0] round_q;     // 1..10 while busy
   logic       busy_q;
   logic       out_valid_q;
   logic       last_round;

   assign last_round = (round_q == 4'd10);
   assign rcon       = aes_rcon(round_q);

   // ##################################################
   // round datapath
   // ##################################################
   aes_key_expand u_key_expand (
      .round_key_i (rkey_q),
      .rcon_i      (rcon),
      .next_key_o  (rkey_next)
   );

   aes_round u_round (
      .state_i     (state_q),
      .round_key_i (rkey_next),
      .last_i      (last_round),
      .state_o     (state_next)
   );

   // ##################################################
   // control
   // ##################################################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         busy_q      <= 1'b0;
         round_q     <= 4'd0;
         out_valid_q <= 1'b0;
      end else begin
         out_valid_q <= busy_q && last_round;
         if (busy_q) begin
            round_q <= round_q + 4'd1;
            if (last_round) begin
               busy_q <= 1'b0;
            end
         end else if (data_in_valid_i) begin  // strobes while busy are dropped
            busy_q  <= 1'b1;
            round_q <= 4'd1;
         end
      end
   end

   // state and key, initial addroundkey on load
   always_ff @(posedge clk) begin
      if (busy_q) begin
         state_q <= state_next;
         rkey_q  <= rkey_next;
      end else if (data_in_valid_i) begin
         state_q <= data_in_i ^ key_in_i;
         rkey_q  <= key_in_i;
      end
   end

   assign data_out_valid_o = out_valid_q;
   assign data_out_o       = state_q;  // holds until next load

endmodule : aes_core

/* logic/aes_cbc_mac.sv */
module aes_cbc_mac import aes_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       start_i,
   input  aes_block_u key_i,
   input  aes_msg_t   msg_i,
   output logic       busy_o,
   output logic       done_o,
   output aes_msg_t   mac_o
);

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_FIRST,
      ST_WAIT_FIRST,
      ST_SECOND,
      ST_WAIT_SECOND,
      ST_DONE
   } mac_state_e;

   mac_state_e state_q;
   mac_state_e state_next;
   aes_block_u first_q;      // first ciphertext, chaining value
   aes_msg_t   mac_q;
   logic       core_in_valid;
   aes_block_u core_in;
   logic       core_out_valid;
   aes_block_u core_out;

   // ##################################################
   // sequencer
   // ##################################################
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state_q <= ST_IDLE;
      end else begin
         state_q <= state_next;
      end
   end

   always_comb begin
      state_next    = state_q;
      core_in_valid = 1'b0;
      core_in       = msg_i.lo;
      unique case (state_q)
         ST_IDLE: begin
            if (start_i) begin
               state_next = ST_FIRST;
            end
         end
         ST_FIRST: begin
            core_in_valid = 1'b1;
            state_next    = ST_WAIT_FIRST;
         end
         ST_WAIT_FIRST: begin
            if (core_out_valid) begin
               state_next = ST_SECOND;
            end
         end
         ST_SECOND: begin
            core_in_valid = 1'b1;
            core_in       = msg_i.hi ^ first_q;  // cbc chaining
            state_next    = ST_WAIT_SECOND;
         end
         ST_WAIT_SECOND: begin
            if (core_out_valid) begin
               state_next = ST_DONE;
            end
         end
         ST_DONE: state_next = ST_IDLE;
         default: state_next = ST_IDLE;
      endcase
   end

   // ##################################################
   // result registers
   // ##################################################
   always_ff @(posedge clk) begin
      if (state_q == ST_WAIT_FIRST && core_out_valid) begin
         first_q <= core_out;
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         mac_q <= '0;
      end else if (state_q == ST_WAIT_SECOND && core_out_valid) begin
         mac_q.hi <= first_q;
         mac_q.lo <= core_out;
      end
   end

   aes_core u_core (
      .clk              (clk),
      .rst_n            (rst_n),
      .data_in_valid_i  (core_in_valid),
      .key_in_i         (key_i),
      .data_in_i        (core_in),
      .data_out_valid_o (core_out_valid),
      .data_out_o       (core_out)
   );

   assign busy_o = (state_q != ST_IDLE);
   assign done_o = (state_q == ST_DONE);
   assign mac_o  = mac_q;

endmodule : aes_cbc_mac

/* logic/sample_collector.sv */
module sample_collector import aes_pkg::*; #(
   parameter int SAMPLE_WIDTH = 32
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [SAMPLE_WIDTH-1:0] sample_i,
   input  logic                    sample_valid_i,
   input  logic                    clear_ovf_i,
   input  logic                    mac_busy_i,
   output logic                    start_o,
   output aes_msg_t                msg_o,
   output logic                    overflow_o
);

   localparam int NUM_SAMPLES = MSG_BITS / SAMPLE_WIDTH;
   localparam int CNT_W       = (NUM_SAMPLES > 1) ? $clog2(NUM_SAMPLES) : 1;

   logic [MSG_BITS+SAMPLE_WIDTH-1:0] fill_cat;
   logic [MSG_BITS-1:0]              fill_q;
   logic [MSG_BITS-1:0]              fill_next;
   aes_msg_t                         hold_q;
   logic [CNT_W-1:0]                 cnt_q;
   logic                             pending_q;   // full message waiting for the mac
   logic                             start_q;
   logic                             ovf_q;
   logic                             accept;
   logic                             last_sample;
   logic                             mac_idle;

   // new sample enters at the top, sample 0 ends in the low bits
   assign fill_cat    = {sample_i, fill_q};
   assign fill_next   = fill_cat[MSG_BITS+SAMPLE_WIDTH-1:SAMPLE_WIDTH];
   assign accept      = sample_valid_i && !pending_q;
   assign last_sample = accept && (cnt_q == CNT_W'(NUM_SAMPLES - 1));
   assign mac_idle    = !mac_busy_i && !start_q;  // start not yet seen as busy

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         cnt_q     <= '0;
         pending_q <= 1'b0;
         start_q   <= 1'b0;
         ovf_q     <= 1'b0;
      end else begin
         start_q <= 1'b0;
         if (accept) begin
            cnt_q <= last_sample ? '0 : cnt_q + 1'b1;
         end
         if (last_sample) begin
            if (mac_idle) begin
               start_q <= 1'b1;
            end else begin
               pending_q <= 1'b1;
            end
         end else if (pending_q && mac_idle) begin
            start_q   <= 1'b1;
            pending_q <= 1'b0;
         end
         // sticky, set wins over clear
         if (sample_valid_i && pending_q) begin
            ovf_q <= 1'b1;
         end else if (clear_ovf_i) begin
            ovf_q <= 1'b0;
         end
      end
   end

   // message payload
   always_ff @(posedge clk) begin
      if (accept) begin
         fill_q <= fill_next;
      end
      if (last_sample && mac_idle) begin
         hold_q <= aes_msg_t'(fill_next);
      end else if (pending_q && mac_idle) begin
         hold_q <= aes_msg_t'(fill_q);
      end
   end

   assign start_o    = start_q;
   assign msg_o      = hold_q;
   assign overflow_o = ovf_q;

endmodule : sample_collector

/* logic/entropy_conditioner.sv */
module entropy_conditioner import aes_pkg::*; #(
   parameter int SAMPLE_WIDTH = 32
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic [SAMPLE_WIDTH-1:0] sample_i,
   input  logic                    sample_valid_i,
   input  logic                    clear_ovf_i,
   input  aes_block_u              key_i,
   output aes_msg_t                mac_o,
   output logic                    done_o,
   output logic                    overflow_o
);

   aes_msg_t msg;
   logic     start;
   logic     mac_busy;

   sample_collector #(
      .SAMPLE_WIDTH (SAMPLE_WIDTH)
   ) u_collector (
      .clk            (clk),
      .rst_n          (rst_n),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .clear_ovf_i    (clear_ovf_i),
      .mac_busy_i     (mac_busy),
      .start_o        (start),
      .msg_o          (msg),
      .overflow_o     (overflow_o)
   );

   aes_cbc_mac u_mac (
      .clk     (clk),
      .rst_n   (rst_n),
      .start_i (start),
      .key_i   (key_i),
      .msg_i   (msg),
      .busy_o  (mac_busy),
      .done_o  (done_o),
      .mac_o   (mac_o)
   );

endmodule : entropy_conditioner

/* test/tb_aes_model.svh */
`ifndef TB_AES_MODEL_SVH
`define TB_AES_MODEL_SVH

// ##################################################
// reference aes-128, byte 0 is the top byte
// ##################################################
logic [7:0]  sbox_tab [0:255];
logic [31:0] rng_state = 32'hb2c7_2665;

// multiply by x, reduce by the field polynomial
function automatic logic [7:0] times_two(input logic [7:0] b);
   logic [8:0] w;
   w = {b, 1'b0};
   if (w[8]) begin
      w = w ^ 9'h11b;
   end
   return w[7:0];
endfunction

// carry-less product, then reduction from the top bit down
function automatic logic [7:0] field_mul(input logic [7:0] a, input logic [7:0] b);
   logic [14:0] p;
   p = '0;
   for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
         p = p ^ (15'(a) << i);
      end
   end
   for (int i = 14; i >= 8; i--) begin
      if (p[i]) begin
         p = p ^ (15'h11b << (i - 8));
      end
   end
   return p[7:0];
endfunction

// s-box table by inverse search and the affine map
function automatic void build_sbox_table();
   logic [7:0] inv;
   logic [7:0] s;
   logic [7:0] aff;
   aff = 8'h63;
   for (int x = 0; x < 256; x++) begin
      inv = 8'h00;  // zero stays zero
      for (int y = 1; y < 256; y++) begin
         if (field_mul(8'(x), 8'(y)) == 8'h01) begin
            inv = 8'(y);
         end
      end
      for (int i = 0; i < 8; i++) begin
         s[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8] ^ inv[(i + 6) % 8]
              ^ inv[(i + 7) % 8] ^ aff[i];
      end
      sbox_tab[x] = s;
   end
endfunction

function automatic logic [127:0] aes_encrypt(input logic [127:0] key, input logic [127:0] pt);
   logic [7:0]   st [0:15];
   logic [7:0]   sh [0:15];
   logic [7:0]   rk [0:15];
   logic [7:0]   t  [0:3];
   logic [7:0]   rc;
   logic [7:0]   a0;
   logic [7:0]   a1;
   logic [7:0]   a2;
   logic [7:0]   a3;
   logic [127:0] ct;
   for (int i = 0; i < 16; i++) begin
      rk[i] = key[127 - 8*i -: 8];
      st[i] = pt[127 - 8*i -: 8] ^ rk[i];
   end
   rc = 8'h01;
   for (int r = 1; r <= 10; r++) begin
      t[0] = sbox_tab[rk[13]] ^ rc;  // rotword + subword + rcon
      t[1] = sbox_tab[rk[14]];
      t[2] = sbox_tab[rk[15]];
      t[3] = sbox_tab[rk[12]];
      for (int i = 0; i < 4; i++) begin
         rk[i] = rk[i] ^ t[i];
      end
      for (int i = 4; i < 16; i++) begin
         rk[i] = rk[i] ^ rk[i - 4];
      end
      rc = times_two(rc);
      for (int c = 0; c < 4; c++) begin
         for (int w = 0; w < 4; w++) begin
            sh[4*c + w] = sbox_tab[st[4*((c + w) % 4) + w]];
         end
      end
      for (int c = 0; c < 4; c++) begin
         a0 = sh[4*c];
         a1 = sh[4*c + 1];
         a2 = sh[4*c + 2];
         a3 = sh[4*c + 3];
         if (r < 10) begin
            st[4*c]     = field_mul(8'h02, a0) ^ field_mul(8'h03, a1) ^ a2 ^ a3;
            st[4*c + 1] = a0 ^ field_mul(8'h02, a1) ^ field_mul(8'h03, a2) ^ a3;
            st[4*c + 2] = a0 ^ a1 ^ field_mul(8'h02, a2) ^ field_mul(8'h03, a3);
            st[4*c + 3] = field_mul(8'h03, a0) ^ a1 ^ a2 ^ field_mul(8'h02, a3);
         end else begin
            st[4*c]     = a0;  // no mixcolumns in the final round
            st[4*c + 1] = a1;
            st[4*c + 2] = a2;
            st[4*c + 3] = a3;
         end
      end
      for (int i = 0; i < 16; i++) begin
         st[i] = st[i] ^ rk[i];
      end
   end
   for (int i = 0; i < 16; i++) begin
      ct[127 - 8*i -: 8] = st[i];
   end
   return ct;
endfunction

// first ciphertext on top, chained ciphertext below
function automatic logic [255:0] cbc_mac(input logic [127:0] key, input logic [255:0] msg);
   logic [127:0] c1;
   logic [127:0] c2;
   c1 = aes_encrypt(key, msg[127:0]);
   c2 = aes_encrypt(key, msg[255:128] ^ c1);
   return {c1, c2};
endfunction

function automatic logic [31:0] xorshift32();
   logic [31:0] x;
   x = rng_state;
   x = x ^ (x << 13);
   x = x ^ (x >> 17);
   x = x ^ (x << 5);
   rng_state = x;
   return x;
endfunction

`endif

/* test/tb_entropy_conditioner.sv */
module tb_entropy_conditioner import aes_pkg::*; ();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int SAMPLE_WIDTH = 32;
   localparam int NUM_SAMPLES  = MSG_BITS / SAMPLE_WIDTH;
   localparam int RESET_CYCLES = 16;
   localparam int DONE_LATENCY = 26;   // last sample edge to done edge
   localparam int DONE_TIMEOUT = 100;
   localparam int DRAIN_LIMIT  = 200;
   localparam int NUM_RANDOM   = 20;

   logic                    clk;
   logic                    rst_n;
   logic [SAMPLE_WIDTH-1:0] sample_i;
   logic                    sample_valid_i;
   logic                    clear_ovf_i;
   aes_block_u              key_i;
   aes_msg_t                mac_o;
   logic                    done_o;
   logic                    overflow_o;

   int       cycle_cnt = 0;
   int       err_cnt   = 0;
   int       check_cnt = 0;
   string    exp_name_q [$];   // one entry per expected done_o
   aes_msg_t exp_mac_q  [$];
   int       exp_due_q  [$];   // expected done edge or -1 if untimed

   `include "tb_aes_model.svh"

   entropy_conditioner #(
      .SAMPLE_WIDTH (SAMPLE_WIDTH)
   ) dut_i (
      .clk            (clk),
      .rst_n          (rst_n),
      .sample_i       (sample_i),
      .sample_valid_i (sample_valid_i),
      .clear_ovf_i    (clear_ovf_i),
      .key_i          (key_i),
      .mac_o          (mac_o),
      .done_o         (done_o),
      .overflow_o     (overflow_o)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // ##################################################
   // checks and report
   // ##################################################
   task automatic check_mac(input string name, input aes_msg_t exp, input aes_msg_t act);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("ERR %s: expected %h got %h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      check_cnt++;
      if (act !== exp) begin
         err_cnt++;
         $display("ERR %s: expected %b got %b", name, exp, act);
      end
   endtask

   task automatic report_and_finish();
      $display("checks: %0d  errors: %0d", check_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   endtask

   // ##################################################
   // stimulus helpers
   // ##################################################
   task automatic drive_sample(input logic [SAMPLE_WIDTH-1:0] s,
                               input logic [BLOCK_BITS-1:0] key);
      @(posedge clk);
      sample_i       <= s;
      sample_valid_i <= 1'b1;
      key_i          <= aes_block_u'(key);
   endtask

   task automatic idle_input();
      @(posedge clk);
      sample_valid_i <= 1'b0;
   endtask

   // call in the time step of the last sample's drive edge
   task automatic push_expected(input string name, input aes_msg_t mac, input logic timed);
      exp_name_q.push_back(name);
      exp_mac_q.push_back(mac);
      exp_due_q.push_back(timed ? cycle_cnt + 1 + DONE_LATENCY : -1);
   endtask

   task automatic send_message(input string name, input logic [MSG_BITS-1:0] msg,
                               input logic [BLOCK_BITS-1:0] key, input aes_msg_t exp,
                               input logic timed);
      for (int k = 0; k < NUM_SAMPLES; k++) begin
         drive_sample(msg[k*SAMPLE_WIDTH +: SAMPLE_WIDTH], key);  // sample k at bit k*width
      end
      push_expected(name, exp, timed);
      idle_input();
   endtask

   task automatic wait_drain(input int limit);
      int n;
      n = 0;
      while (exp_mac_q.size() > 0 && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (exp_mac_q.size() > 0) begin
         err_cnt++;
         $display("results still outstanding after %0d cycles", limit);
      end
      repeat (2) @(posedge clk);  // mac back to idle
   endtask

   task automatic wait_for_overflow(input logic level, input int limit);
      int n;
      n = 0;
      @(posedge clk);
      while (overflow_o !== level && n < limit) begin
         @(posedge clk);
         n++;
      end
      if (overflow_o !== level) begin
         $display("overflow_o did not reach %b within %0d cycles", level, limit);
      end
   endtask

   // ##################################################
   // compare process
   // ##################################################
   initial begin : compare_proc
      int       waited;
      int       due;
      logic     timed_out;
      string    name;
      aes_msg_t exp_mac;
      timed_out = 1'b0;
      while (!timed_out) begin
         @(posedge clk);
         if (exp_mac_q.size() > 0) begin
            waited = 0;
            while (done_o !== 1'b1 && waited < DONE_TIMEOUT) begin
               @(posedge clk);
               waited++;
            end
            if (done_o === 1'b1) begin
               name    = exp_name_q.pop_front();
               exp_mac = exp_mac_q.pop_front();
               due     = exp_due_q.pop_front();
               check_mac(name, exp_mac, mac_o);
               if (due >= 0) begin
                  check_flag({name, " latency"}, 1'b1, logic'(cycle_cnt == due));
               end
            end else begin
               timed_out = 1'b1;
            end
         end else if (rst_n === 1'b1 && done_o === 1'b1) begin
            err_cnt++;
            $display("done_o pulsed while no result was expected");
         end
      end
      err_cnt++;
      $display("timeout: done_o did not arrive within %0d cycles", DONE_TIMEOUT);
      report_and_finish();
   end

   // ##################################################
   // main sequence
   // ##################################################
   initial begin : main_proc
      logic [MSG_BITS-1:0]   msg;
      logic [MSG_BITS-1:0]   exp;
      logic [BLOCK_BITS-1:0] key;
      logic [MSG_BITS-1:0]   burst [0:2];
      rst_n          = 1'b0;
      sample_i       = '0;
      sample_valid_i = 1'b0;
      clear_ovf_i    = 1'b0;
      key_i          = '0;
      build_sbox_table();
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
      @(posedge clk);
      check_flag("reset done_o", 1'b0, done_o);
      check_flag("reset overflow_o", 1'b0, overflow_o);
      check_mac("reset mac_o", '0, mac_o);

      // fips-197 appendix b block as the lo half
      key = 128'h2b7e151628aed2a6abf7158809cf4f3c;
      msg = {128'h00112233445566778899aabbccddeeff, 128'h3243f6a8885a308d313198a2e0370734};
      exp = cbc_mac(key, msg);
      exp[MSG_BITS-1:BLOCK_BITS] = 128'h3925841d02dc09fbdc118597196a0b32;
      send_message("fips vector", msg, key, aes_msg_t'(exp), 1'b1);
      wait_drain(DRAIN_LIMIT);

      for (int m = 0; m < NUM_RANDOM; m++) begin
         for (int i = 0; i < 4; i++) begin
            key[32*i +: 32] = xorshift32();
         end
         for (int i = 0; i < 8; i++) begin
            msg[32*i +: 32] = xorshift32();
         end
         send_message($sformatf("random %0d", m), msg, key, aes_msg_t'(cbc_mac(key, msg)), 1'b1);
         wait_drain(DRAIN_LIMIT);
      end
      check_flag("overflow idle", 1'b0, overflow_o);  // nothing dropped so far

      // three messages back to back so the third meets a pending one
      for (int i = 0; i < 4; i++) begin
         key[32*i +: 32] = xorshift32();
      end
      for (int m = 0; m < 3; m++) begin
         for (int i = 0; i < 8; i++) begin
            burst[m][32*i +: 32] = xorshift32();
         end
      end
      for (int m = 0; m < 3; m++) begin
         for (int k = 0; k < NUM_SAMPLES; k++) begin
            drive_sample(burst[m][k*SAMPLE_WIDTH +: SAMPLE_WIDTH], key);
         end
         if (m < 2) begin
            push_expected($sformatf("burst %0d", m), aes_msg_t'(cbc_mac(key, burst[m])), 1'b0);
         end
      end
      idle_input();
      wait_for_overflow(1'b1, 10);
      check_flag("overflow set", 1'b1, overflow_o);
      wait_drain(DRAIN_LIMIT);
      check_flag("overflow held", 1'b1, overflow_o);  // sticky until cleared
      @(posedge clk);
      clear_ovf_i <= 1'b1;
      @(posedge clk);
      clear_ovf_i <= 1'b0;
      wait_for_overflow(1'b0, 10);
      check_flag("overflow cleared", 1'b0, overflow_o);

      wait_drain(DRAIN_LIMIT);
      report_and_finish();
   end

endmodule : tb_entropy_conditioner

/* tb.f */
+incdir+test
logic/aes_pkg.sv
logic/aes_key_expand.sv
logic/aes_round.sv
logic/aes_core.sv
logic/aes_cbc_mac.sv
logic/sample_collector.sv
logic/entropy_conditioner.sv
test/tb_entropy_conditioner.sv

/* Bender.yml */
package:
  name: entropy_conditioner

sources:
  - logic/aes_pkg.sv
  - logic/aes_key_expand.sv
  - logic/aes_round.sv
  - logic/aes_core.sv
  - logic/aes_cbc_mac.sv
  - logic/sample_collector.sv
  - logic/entropy_conditioner.sv
  - target: test
    include_dirs:
      - test
    files:
      - test/tb_entropy_conditioner.sv
